// File: hw/draw_pkg.sv
/*
 * shared types and constants for the triangle engine
 * coordinate type, APB data word union, register offsets, colour index width
 */

`default_nettype none

package draw_pkg;

    typedef logic signed [15:0] coord_t;  // signed screen coordinate

    localparam int cidx_w = 4;  // colour index bits

    // one APB data word, seen as a vertex or as the control word
    typedef union packed {
        struct packed {
            coord_t y;  // upper half
            coord_t x;  // lower half
        } vtx;
        struct packed {
            logic [23:0]       rsvd_hi;
            logic [cidx_w-1:0] cidx;     // bits 7:4
            logic [2:0]        rsvd_lo;
            logic              start;    // bit 0
        } ctrl;
    } reg_word_t;

    // byte offsets on the 13-bit APB address
    localparam logic [12:0] reg_v0     = 13'h0000;
    localparam logic [12:0] reg_v1     = 13'h0004;
    localparam logic [12:0] reg_v2     = 13'h0008;
    localparam logic [12:0] reg_ctrl   = 13'h000C;
    localparam logic [12:0] reg_status = 13'h0010;  // bit 0 busy, bit 1 done
    localparam logic [12:0] reg_clip   = 13'h0014;
    localparam logic [12:0] pix_base   = 13'h1000;  // pixel window

endpackage

`default_nettype wire

// File: hw/draw_line.sv
/*
 * Bresenham line rasterizer
 * one pixel per clock from (xa,ya) to (xb,yb), endpoints included
 */

`timescale 1ns/1ps
`default_nettype none

module draw_line (
    input  wire logic             clk_100m,
    input  wire logic             reset,
    input  wire logic             start,
    input  wire draw_pkg::coord_t xa,
    input  wire draw_pkg::coord_t ya,
    input  wire draw_pkg::coord_t xb,
    input  wire draw_pkg::coord_t yb,
    output draw_pkg::coord_t      x,
    output draw_pkg::coord_t      y,
    output logic                  drawing,
    output logic                  done
);
    logic signed [16:0] dx_in, dy_in;  // deltas of the requested line
    logic signed [16:0] dx, dy;        // dy held negative
    logic signed [17:0] err;
    logic signed [18:0] e2;
    logic               step_x, step_y;
    logic               x_neg, y_neg;  // step direction
    draw_pkg::coord_t   x_end, y_end;
    logic               at_end;

    always_comb begin
        dx_in  = (xb > xa) ? 17'(xb) - 17'(xa) : 17'(xa) - 17'(xb);
        dy_in  = (yb > ya) ? 17'(ya) - 17'(yb) : 17'(yb) - 17'(ya);
        e2     = 19'(err) <<< 1;
        step_x = (e2 >= 19'(dy));
        step_y = (e2 <= 19'(dx));
        at_end = (x == x_end) && (y == y_end);
    end

    // control
    always_ff @(posedge clk_100m) begin
        if (reset) begin
            drawing <= 1'b0;
            done    <= 1'b0;
        end else begin
            done <= 1'b0;
            if (start) begin
                drawing <= 1'b1;
            end else if (drawing && at_end) begin
                drawing <= 1'b0;
                done    <= 1'b1;  // one cycle after the last pixel
            end
        end
    end

    // coordinate and error datapath
    always_ff @(posedge clk_100m) begin
        if (start) begin
            x     <= xa;
            y     <= ya;
            x_end <= xb;
            y_end <= yb;
            x_neg <= (xb < xa);
            y_neg <= (yb < ya);
            dx    <= dx_in;
            dy    <= dy_in;
            err   <= 18'(dx_in) + 18'(dy_in);
        end else if (drawing && !at_end) begin
            if (step_x) begin
                x <= x_neg ? x - 16'sd1 : x + 16'sd1;
            end
            if (step_y) begin
                y <= y_neg ? y - 16'sd1 : y + 16'sd1;
            end
            err <= err + (step_x ? 18'(dy) : 18'sd0) + (step_y ? 18'(dx) : 18'sd0);
        end
    end

endmodule

`default_nettype wire

// File: hw/draw_triangle.sv
/*
 * triangle outline drawer
 * runs the edges v0-v1, v1-v2 and v2-v0 through one line rasterizer
 */

`timescale 1ns/1ps
`default_nettype none

module draw_triangle (
    input  wire logic             clk_100m,
    input  wire logic             reset,
    input  wire logic             start,
    input  wire draw_pkg::coord_t x0, y0, x1, y1, x2, y2,
    output draw_pkg::coord_t      x,
    output draw_pkg::coord_t      y,
    output logic                  drawing,
    output logic                  busy,
    output logic                  done
);
    draw_pkg::coord_t vx0, vy0, vx1, vy1, vx2, vy2;  // vertices held for the draw
    draw_pkg::coord_t xa, ya, xb, yb;                // current edge
    logic [1:0]       edge_idx;
    logic             line_start;
    logic             line_done;

    always_comb begin
        case (edge_idx)
            2'd0: begin
                xa = vx0; ya = vy0;
                xb = vx1; yb = vy1;
            end
            2'd1: begin
                xa = vx1; ya = vy1;
                xb = vx2; yb = vy2;
            end
            default: begin  // closing edge
                xa = vx2; ya = vy2;
                xb = vx0; yb = vy0;
            end
        endcase
    end

    always_ff @(posedge clk_100m) begin
        if (reset) begin
            busy       <= 1'b0;
            done       <= 1'b0;
            line_start <= 1'b0;
            edge_idx   <= 2'd0;
        end else begin
            line_start <= 1'b0;
            done       <= 1'b0;
            if (start && !busy) begin
                busy       <= 1'b1;
                edge_idx   <= 2'd0;
                line_start <= 1'b1;
            end else if (busy && line_done) begin
                if (edge_idx == 2'd2) begin
                    busy <= 1'b0;
                    done <= 1'b1;
                end else begin
                    edge_idx   <= edge_idx + 2'd1;
                    line_start <= 1'b1;  // next edge right after done
                end
            end
        end
    end

    always_ff @(posedge clk_100m) begin
        if (start && !busy) begin
            vx0 <= x0; vy0 <= y0;
            vx1 <= x1; vy1 <= y1;
            vx2 <= x2; vy2 <= y2;
        end
    end

    draw_line line_inst (
        .clk_100m (clk_100m),
        .reset    (reset),
        .start    (line_start),
        .xa       (xa),
        .ya       (ya),
        .xb       (xb),
        .yb       (yb),
        .x        (x),
        .y        (y),
        .drawing  (drawing),
        .done     (line_done)
    );

endmodule

`default_nettype wire

// File: hw/pixel_store.sv
/*
 * framebuffer of colour indices
 * clipped write port, reset clear sweep and registered read port
 */

`timescale 1ns/1ps
`default_nettype none

module pixel_store #(
    parameter int width  = 32,
    parameter int height = 32
) (
    input  wire logic                              clk_100m,
    input  wire logic                              reset,
    input  wire logic                              we,
    input  wire draw_pkg::coord_t                  x,
    input  wire draw_pkg::coord_t                  y,
    input  wire logic [draw_pkg::cidx_w-1:0]       cidx,
    input  wire logic                              rd_en,
    input  wire logic [$clog2(width*height)-1:0]   rd_addr,
    output logic [draw_pkg::cidx_w-1:0]            rd_data,
    output logic                                   clip,
    output logic                                   sweep_busy
);
    localparam int depth = width * height;
    localparam int aw    = $clog2(depth);

    logic [draw_pkg::cidx_w-1:0] mem [depth];
    logic                        in_range;
    logic [aw-1:0]               wr_addr;
    logic [aw-1:0]               sweep_addr;

    assign in_range = (x >= 16'sd0) && (x < width) && (y >= 16'sd0) && (y < height);
    assign wr_addr  = aw'(32'(y) * width + 32'(x));  // row major
    assign clip     = we && !in_range;

    // clear sweep after reset
    always_ff @(posedge clk_100m) begin
        if (reset) begin
            sweep_busy <= 1'b1;
            sweep_addr <= '0;
        end else if (sweep_busy) begin
            sweep_addr <= sweep_addr + 1'b1;
            if (sweep_addr == aw'(depth - 1)) begin
                sweep_busy <= 1'b0;
            end
        end
    end

    // single write port shared by sweep and drawer
    always_ff @(posedge clk_100m) begin
        if (sweep_busy) begin
            mem[sweep_addr] <= '0;
        end else if (we && in_range) begin
            mem[wr_addr] <= cidx;
        end
    end

    always_ff @(posedge clk_100m) begin
        if (rd_en) begin
            rd_data <= mem[rd_addr];  // valid the cycle after rd_en
        end
    end

endmodule

`default_nettype wire

// File: hw/draw_regs.sv
/*
 * APB register block for the triangle engine
 * vertex, control, status and clip count registers plus the pixel read window
 */

`timescale 1ns/1ps
`default_nettype none

module draw_regs #(
    parameter int width  = 32,
    parameter int height = 32
) (
    input  wire logic                                  clk_100m,
    input  wire logic                                  reset,
    input  wire logic                                  psel,
    input  wire logic                                  penable,
    input  wire logic                                  pwrite,
    input  wire logic [12:0]                           paddr,
    input  wire logic [31:0]                           pwdata,
    output logic [31:0]                                prdata,
    output logic                                       pready,
    output logic                                       pslverr,
    input  wire logic                                  busy,
    input  wire logic                                  done,
    input  wire logic                                  clip,
    input  wire logic                                  sweep_busy,
    input  wire logic [draw_pkg::cidx_w-1:0]           rd_data,
    output draw_pkg::coord_t                           x0, y0, x1, y1, x2, y2,
    output logic [draw_pkg::cidx_w-1:0]                cidx,
    output logic                                       start,
    output logic                                       rd_en,
    output logic [$clog2(width*height)-1:0]            rd_addr
);
    localparam int aw = $clog2(width*height);

    draw_pkg::reg_word_t wr_word;  // pwdata decoded
    draw_pkg::reg_word_t rd_word;  // read data before the bus
    logic        access;
    logic        busy_any;
    logic        reg_hit, pix_hit, unmapped;
    logic        is_ctrl;
    logic        pix_rd;
    logic        rd_pend;          // pixel read wait state
    logic        start_refused;
    logic        done_flag;
    logic [15:0] clip_cnt;

    assign wr_word  = pwdata;
    assign access   = psel && penable;
    assign busy_any = busy || sweep_busy;  // drawing or clearing

    assign is_ctrl  = (paddr == draw_pkg::reg_ctrl);
    assign reg_hit  = (paddr == draw_pkg::reg_v0) || (paddr == draw_pkg::reg_v1) ||
                      (paddr == draw_pkg::reg_v2) || is_ctrl ||
                      (paddr == draw_pkg::reg_status) || (paddr == draw_pkg::reg_clip);
    assign pix_hit  = paddr[12] && ({22'd0, paddr[11:2]} < 32'(width * height));
    assign unmapped = !(reg_hit || pix_hit);
    assign pix_rd   = pix_hit && !pwrite;

    // pixel reads wait one cycle for the registered store
    assign pready  = access && (!pix_rd || rd_pend);
    assign rd_en   = access && pix_rd && !rd_pend;
    assign rd_addr = paddr[aw+1:2];

    assign start_refused = pwrite && is_ctrl && wr_word.ctrl.start && busy_any;
    assign pslverr       = pready && (unmapped || start_refused);
    assign start = access && pwrite && is_ctrl && wr_word.ctrl.start && !busy_any;

    always_ff @(posedge clk_100m) begin
        if (reset) begin
            rd_pend   <= 1'b0;
            done_flag <= 1'b0;
            clip_cnt  <= 16'd0;
        end else begin
            rd_pend <= rd_en;
            if (start) begin
                done_flag <= 1'b0;
                clip_cnt  <= 16'd0;
            end else begin
                if (done) done_flag <= 1'b1;  // sticky until next start
                if (clip) clip_cnt <= clip_cnt + 16'd1;
            end
        end
    end

    // vertex and colour payload
    always_ff @(posedge clk_100m) begin
        if (access && pwrite) begin
            case (paddr)
                draw_pkg::reg_v0: begin
                    x0 <= wr_word.vtx.x;
                    y0 <= wr_word.vtx.y;
                end
                draw_pkg::reg_v1: begin
                    x1 <= wr_word.vtx.x;
                    y1 <= wr_word.vtx.y;
                end
                draw_pkg::reg_v2: begin
                    x2 <= wr_word.vtx.x;
                    y2 <= wr_word.vtx.y;
                end
                draw_pkg::reg_ctrl: if (!busy_any) cidx <= wr_word.ctrl.cidx;
                default: ;  // status and clip are read only
            endcase
        end
    end

    always_comb begin
        rd_word = '0;
        case (paddr)
            draw_pkg::reg_v0: begin
                rd_word.vtx.x = x0;
                rd_word.vtx.y = y0;
            end
            draw_pkg::reg_v1: begin
                rd_word.vtx.x = x1;
                rd_word.vtx.y = y1;
            end
            draw_pkg::reg_v2: begin
                rd_word.vtx.x = x2;
                rd_word.vtx.y = y2;
            end
            draw_pkg::reg_ctrl:   rd_word.ctrl.cidx = cidx;
            draw_pkg::reg_status: rd_word = {30'd0, done_flag, busy_any};
            draw_pkg::reg_clip:   rd_word = {16'd0, clip_cnt};
            default: if (pix_hit) rd_word = 32'(rd_data);
        endcase
    end

    assign prdata = rd_word;

endmodule

`default_nettype wire

// File: hw/triangle_engine.sv
/*
 * triangle engine top level
 * APB registers, triangle rasterizer and framebuffer store
 */

`timescale 1ns/1ps
`default_nettype none

module triangle_engine #(
    parameter int width  = 32,
    parameter int height = 32
) (
    input  wire logic        clk_100m,
    input  wire logic        reset,
    input  wire logic        psel,
    input  wire logic        penable,
    input  wire logic        pwrite,
    input  wire logic [12:0] paddr,
    input  wire logic [31:0] pwdata,
    output logic [31:0]      prdata,
    output logic             pready,
    output logic             pslverr
);
    localparam int aw = $clog2(width * height);

    draw_pkg::coord_t            x0, y0, x1, y1, x2, y2;  // vertex registers
    draw_pkg::coord_t            fb_x, fb_y;              // pixel being drawn
    logic [draw_pkg::cidx_w-1:0] cidx;
    logic [draw_pkg::cidx_w-1:0] rd_data;
    logic [aw-1:0]               rd_addr;
    logic                        start, busy, done, drawing;
    logic                        clip, sweep_busy, rd_en;

    draw_regs #(
        .width  (width),
        .height (height)
    ) regs_inst (
        .clk_100m   (clk_100m),
        .reset      (reset),
        .psel       (psel),
        .penable    (penable),
        .pwrite     (pwrite),
        .paddr      (paddr),
        .pwdata     (pwdata),
        .prdata     (prdata),
        .pready     (pready),
        .pslverr    (pslverr),
        .busy       (busy),
        .done       (done),
        .clip       (clip),
        .sweep_busy (sweep_busy),
        .rd_data    (rd_data),
        .x0 (x0), .y0 (y0), .x1 (x1), .y1 (y1), .x2 (x2), .y2 (y2),
        .cidx       (cidx),
        .start      (start),
        .rd_en      (rd_en),
        .rd_addr    (rd_addr)
    );

    draw_triangle triangle_inst (
        .clk_100m (clk_100m),
        .reset    (reset),
        .start    (start),
        .x0 (x0), .y0 (y0), .x1 (x1), .y1 (y1), .x2 (x2), .y2 (y2),
        .x        (fb_x),
        .y        (fb_y),
        .drawing  (drawing),
        .busy     (busy),
        .done     (done)
    );

    pixel_store #(
        .width  (width),
        .height (height)
    ) store_inst (
        .clk_100m   (clk_100m),
        .reset      (reset),
        .we         (drawing),  // every drawn pixel is a write
        .x          (fb_x),
        .y          (fb_y),
        .cidx       (cidx),
        .rd_en      (rd_en),
        .rd_addr    (rd_addr),
        .rd_data    (rd_data),
        .clip       (clip),
        .sweep_busy (sweep_busy)
    );

endmodule

`default_nettype wire

// File: verif/tb_model.svh
/*
 * testbench model with LCG, Bresenham reference and model framebuffer
 * APB transfer tasks
 */

`ifndef tb_model_svh
`define tb_model_svh

logic [31:0]                 seed = 32'd48;
logic [draw_pkg::cidx_w-1:0] model_fb [width*height];
int                          model_clips;  // out-of-range pixels of the last draw

function automatic logic [31:0] next_random();
    seed = seed * 32'd1103515245 + 32'd12345;
    return seed;
endfunction

function automatic int random_in(input int lo, input int hi);
    logic [31:0] r;
    r = next_random();
    return lo + int'(r[30:16]) % (hi - lo + 1);  // upper bits have the longer period
endfunction

task automatic plot_pixel(input int px, input int py, input int col);
    if (px >= 0 && px < width && py >= 0 && py < height) begin
        model_fb[py * width + px] = col[draw_pkg::cidx_w-1:0];
    end else begin
        model_clips++;
    end
endtask

// integer Bresenham, endpoints included
task automatic model_line(input int xa, input int ya, input int xb, input int yb,
                          input int col);
    int  px, py, dx, dy, sx, sy, err, e2;
    bit  finished;
    px = xa;
    py = ya;
    dx = (xb > xa) ? xb - xa : xa - xb;
    dy = (yb > ya) ? ya - yb : yb - ya;  // kept negative
    sx = (xb < xa) ? -1 : 1;
    sy = (yb < ya) ? -1 : 1;
    err = dx + dy;
    finished = 0;
    while (!finished) begin
        plot_pixel(px, py, col);
        if (px == xb && py == yb) begin
            finished = 1;
        end else begin
            e2 = 2 * err;
            if (e2 >= dy) begin
                err += dy;
                px += sx;
            end
            if (e2 <= dx) begin
                err += dx;
                py += sy;
            end
        end
    end
endtask

task automatic model_triangle(input int ax, input int ay, input int bx, input int by,
                              input int cx, input int cy, input int col);
    model_clips = 0;  // clip count restarts with each draw
    model_line(ax, ay, bx, by, col);
    model_line(bx, by, cx, cy, col);
    model_line(cx, cy, ax, ay, col);
endtask

// one APB transfer, setup then access until pready
task automatic bus_transfer(input logic wr, input logic [12:0] addr,
                            input logic [31:0] wdata, output logic [31:0] rdata,
                            output logic err);
    int waits;
    @(posedge clk_100m);
    #1;
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = wr;
    paddr   = addr;
    pwdata  = wdata;
    @(posedge clk_100m);
    #1;
    penable = 1'b1;
    waits   = 0;
    #5;  // mid cycle, outputs settled
    while (!pready) begin
        waits++;
        if (waits > 16) stop_on_timeout("APB transfer never saw pready");
        @(posedge clk_100m);
        #6;
    end
    // one wait state on pixel reads only
    check($sformatf("wait states at 0x%04h", addr),
          (!wr && addr >= draw_pkg::pix_base) ? 32'd1 : 32'd0, 32'(waits));
    rdata = prdata;
    err   = pslverr;
    @(posedge clk_100m);
    #1;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
endtask

task automatic write_word(input logic [12:0] addr, input logic [31:0] data,
                          output logic err);
    logic [31:0] unused;
    bus_transfer(1'b1, addr, data, unused, err);
endtask

task automatic read_word(input logic [12:0] addr, output logic [31:0] data,
                         output logic err);
    bus_transfer(1'b0, addr, 32'd0, data, err);
endtask

`endif

// File: verif/tb_triangle_engine.sv
/*
 * testbench for the triangle engine
 * random triangles over APB checked against a model framebuffer
 */

`timescale 1ns/1ps
`default_nettype none

module tb_triangle_engine;
    localparam int width  = 32;
    localparam int height = 32;

    logic        clk_100m;
    logic        reset;
    logic        psel, penable, pwrite;
    logic [12:0] paddr;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic        pready, pslverr;

    `include "tb_model.svh"

    triangle_engine #(
        .width  (width),
        .height (height)
    ) UUT (
        .clk_100m (clk_100m),
        .reset    (reset),
        .psel     (psel),
        .penable  (penable),
        .pwrite   (pwrite),
        .paddr    (paddr),
        .pwdata   (pwdata),
        .prdata   (prdata),
        .pready   (pready),
        .pslverr  (pslverr)
    );

    always #5 clk_100m = ~clk_100m;  // 100 MHz

    task automatic check(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
        if (expected !== actual) begin
            $display("error %s expected 0x%08h actual 0x%08h", name, expected, actual);
            $display("Test failures found");
            $fatal(1);
        end
    endtask

    task automatic stop_on_timeout(input string what);
        $display("timeout: %s", what);
        $display("Test failures found");
        $fatal(1);
    endtask

    function automatic logic [31:0] vertex_word(input int vx, input int vy);
        return {16'(vy), 16'(vx)};  // y high, x low
    endfunction

    task automatic wait_idle(input int limit);
        logic [31:0] status;
        logic        err;
        int          polls;
        polls = 0;
        read_word(draw_pkg::reg_status, status, err);
        while (status[0]) begin
            polls++;
            if (polls > limit) stop_on_timeout("engine stayed busy past the poll limit");
            read_word(draw_pkg::reg_status, status, err);
        end
    endtask

    task automatic start_triangle(input string name, input int ax, input int ay,
                                  input int bx, input int by, input int cx, input int cy,
                                  input int col);
        logic err;
        write_word(draw_pkg::reg_v0, vertex_word(ax, ay), err);
        write_word(draw_pkg::reg_v1, vertex_word(bx, by), err);
        write_word(draw_pkg::reg_v2, vertex_word(cx, cy), err);
        write_word(draw_pkg::reg_ctrl, {24'd0, 4'(col), 3'd0, 1'b1}, err);
        check({name, " start pslverr"}, 32'd0, 32'(err));
        model_triangle(ax, ay, bx, by, cx, cy, col);
    endtask

    task automatic finish_triangle(input string name);
        logic [31:0] data;
        logic        err;
        wait_idle(400);
        read_word(draw_pkg::reg_status, data, err);
        check({name, " status"}, 32'h2, data);  // done, not busy
        read_word(draw_pkg::reg_clip, data, err);
        check({name, " clip count"}, 32'(model_clips), data);
    endtask

    task automatic compare_frame(input string name);
        logic [31:0] data;
        logic        err;
        for (int i = 0; i < width * height; i++) begin
            read_word(draw_pkg::pix_base + 13'(i * 4), data, err);
            check($sformatf("%s pixel %0d", name, i), 32'(model_fb[i]), data);
        end
    endtask

    initial begin
        logic [31:0] data;
        logic        err;
        int          px, py;
        clk_100m = 1'b0;
        reset    = 1'b1;
        psel     = 1'b0;
        penable  = 1'b0;
        pwrite   = 1'b0;
        paddr    = '0;
        pwdata   = '0;
        for (int i = 0; i < width * height; i++) model_fb[i] = '0;
        repeat (4) @(posedge clk_100m);
        #1;
        reset = 1'b0;

        // reset state, after the clear sweep
        wait_idle(2000);
        read_word(draw_pkg::reg_status, data, err);
        check("reset status", 32'd0, data);
        read_word(draw_pkg::reg_clip, data, err);
        check("reset clip count", 32'd0, data);
        compare_frame("reset");

        start_triangle("single", random_in(0, 31), random_in(0, 31), random_in(0, 31),
                       random_in(0, 31), random_in(0, 31), random_in(0, 31),
                       random_in(1, 15));
        finish_triangle("single");
        compare_frame("single");

        for (int t = 0; t < 20; t++) begin
            start_triangle($sformatf("clip %0d", t), random_in(-16, 47), random_in(-16, 47),
                           random_in(-16, 47), random_in(-16, 47), random_in(-16, 47),
                           random_in(-16, 47), random_in(1, 15));
            finish_triangle($sformatf("clip %0d", t));
            compare_frame($sformatf("clip %0d", t));
        end

        // long edges keep the engine busy through the next writes
        start_triangle("refused", 2, 3, 29, 10, 12, 30,
                       random_in(1, 14));  // differs from the refused colour
        read_word(draw_pkg::reg_status, data, err);
        check("refused busy bit", 32'd1, 32'(data[0]));
        write_word(draw_pkg::reg_ctrl, {24'd0, 4'hF, 3'd0, 1'b1}, err);
        check("refused pslverr", 32'd1, 32'(err));
        finish_triangle("refused");
        compare_frame("refused");

        write_word(draw_pkg::reg_v0, vertex_word(-5, -16), err);
        write_word(draw_pkg::reg_v1, vertex_word(300, -1), err);
        write_word(draw_pkg::reg_v2, vertex_word(-32768, 32767), err);
        write_word(13'h0018, 32'hFFFF_FFFF, err);
        check("unmapped pslverr", 32'd1, 32'(err));
        write_word(13'h0FFC, 32'h1234_5678, err);
        check("below window pslverr", 32'd1, 32'(err));
        write_word(draw_pkg::pix_base + 13'd148, 32'h0000_000F, err);
        check("pixel write pslverr", 32'd0, 32'(err));  // ignored quietly
        read_word(draw_pkg::reg_v0, data, err);
        check("v0 readback", vertex_word(-5, -16), data);
        read_word(draw_pkg::reg_v1, data, err);
        check("v1 readback", vertex_word(300, -1), data);
        read_word(draw_pkg::reg_v2, data, err);
        check("v2 readback", vertex_word(-32768, 32767), data);
        compare_frame("decode");

        px = random_in(0, 31);
        py = random_in(0, 31);
        start_triangle("degenerate", px, py, px, py, px, py, random_in(1, 15));
        finish_triangle("degenerate");
        read_word(draw_pkg::reg_clip, data, err);
        check("degenerate clip count", 32'd0, data);
        compare_frame("degenerate");

        $display("All tests passed!");
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog.f
+incdir+verif
hw/draw_pkg.sv
hw/draw_line.sv
hw/draw_triangle.sv
hw/pixel_store.sv
hw/draw_regs.sv
hw/triangle_engine.sv
verif/tb_triangle_engine.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the triangle engine testbench with Verilator

cd "$(dirname "$0")" || exit 1

log=sim.log
fail_msg="Test failures found"

verilator --binary --timing -Wno-fatal \
    --top-module tb_triangle_engine \
    -f verilog.f \
    -o tb_sim
build_status=$?
if [ $build_status -ne 0 ]; then
    echo "build failed with status $build_status"
    exit 1
fi

./obj_dir/tb_sim > "$log" 2>&1
run_status=$?
cat "$log"

if grep -q "$fail_msg" "$log"; then
    echo "simulation reported failures, see $log"
    exit 1
fi

if [ $run_status -ne 0 ]; then
    echo "simulation exited with status $run_status"
    exit 1
fi

if ! grep -q "All tests passed!" "$log"; then
    echo "simulation ended without a result, see $log"
    exit 1
fi

echo "simulation passed"
exit 0
